/* include/csr_macros.svh */
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

`default_nettype none

// Register width of the unit, fixed
`define CSR_XLEN 32

////////////////////////////////////////
// Machine CSR addresses
////////////////////////////////////////

`define CSR_MSTATUS       12'h300
`define CSR_MIE           12'h304
`define CSR_MTVEC         12'h305
`define CSR_MCOUNTINHIBIT 12'h320
`define CSR_MSCRATCH      12'h340
`define CSR_MEPC          12'h341
`define CSR_MCAUSE        12'h342
`define CSR_MTVAL         12'h343
`define CSR_MIP           12'h344

// Machine counters, read-write
`define CSR_MCYCLE        12'hB00
`define CSR_MINSTRET      12'hB02

// User copies of the counters, read-only
`define CSR_CYCLE         12'hC00
`define CSR_INSTRET       12'hC02

// Bit positions inside mstatus
`define MSTATUS_MIE  3
`define MSTATUS_MPIE 7
// Low bit of the two-bit MPP field
`define MSTATUS_MPP  11

`default_nettype wire

`endif

/* logic/csrPkg.sv */
`default_nettype none

package csrPkg;

  ////////////////////////////////////////
  // CSR instruction operations
  ////////////////////////////////////////

  // Taken from funct3[1:0] of the CSR instruction
  // funct3[2] only picks the immediate source and is not part of the op
  typedef enum logic [1:0] {
    // No CSR op, the access only reads
    csrNone = 2'b00,
    // csrrw / csrrwi, the source replaces the register
    csrRw   = 2'b01,
    // csrrs / csrrsi, the source bits are set
    csrRs   = 2'b10,
    // csrrc / csrrci, the source bits are cleared
    csrRc   = 2'b11
  } csrOp;

  ////////////////////////////////////////
  // Privilege levels
  ////////////////////////////////////////

  // Encoded as in the privileged spec so that CSR address bits 9:8
  // can be compared against the level directly
  // Supervisor (01) is not built
  typedef enum logic [1:0] {
    // User mode
    privU = 2'b00,
    // Machine mode, also the level after reset
    privM = 2'b11
  } privLevel;

endpackage

`default_nettype wire

/* logic/csrAccessIf.sv */
`include "csr_macros.svh"
`default_nettype none

// One access port between the access stage and a register bank
interface csrAccessIf;

  // CSR address from instr[31:20]
  logic [11:0]          adr;
  // One-cycle write strobe, the bank applies it at the edge
  logic                 write;
  // Value to store when write is high
  logic [`CSR_XLEN-1:0] writeVal;
  // Read data, zero for addresses the bank does not own
  logic [`CSR_XLEN-1:0] readVal;
  // Bank owns adr
  logic                 hit;

  // Access stage side
  modport stage (
    output adr,
    output write,
    output writeVal,
    input  readVal,
    input  hit
  );

  // Register bank side
  modport bank (
    input  adr,
    input  write,
    input  writeVal,
    output readVal,
    output hit
  );

endinterface

`default_nettype wire

/* logic/csrAccessStage.sv */
`include "csr_macros.svh"
`default_nettype none

module csrAccessStage (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,
  input  logic                 flush,
  input  logic                 csrValid,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] srcA,
  input  csrPkg::privLevel     privMode,
  csrAccessIf.stage            machineBus,
  csrAccessIf.stage            counterBus,
  output logic [`CSR_XLEN-1:0] readValW,
  output logic                 illegal
);

  logic [11:0]          adr;
  logic [4:0]           rs1;
  logic                 useImm;
  csrPkg::csrOp         op;
  logic [`CSR_XLEN-1:0] src;
  logic [`CSR_XLEN-1:0] readValM;
  logic [`CSR_XLEN-1:0] writeValM;
  logic                 anyHit;
  logic                 writesReg;
  logic                 privTooLow;
  logic                 readOnlyWrite;
  logic                 doWrite;

  ////////////////////////////////////////
  // Instruction decode
  ////////////////////////////////////////

  assign adr    = instr[31:20];
  assign rs1    = instr[19:15];
  assign useImm = instr[14];
  assign op     = csrPkg::csrOp'(instr[13:12]);

  // Register value or zero-extended uimm
  assign src = useImm ? {{(`CSR_XLEN-5){1'b0}}, rs1} : srcA;

  // Only one bank hits, so OR is enough to merge
  assign readValM = machineBus.readVal | counterBus.readVal;
  assign anyHit   = machineBus.hit | counterBus.hit;

  // Set and clear with rs1/uimm field of zero only read
  assign writesReg = (op == csrPkg::csrRw) ||
                     ((op == csrPkg::csrRs || op == csrPkg::csrRc) && (rs1 != 5'd0));

  // Read-modify-write value
  always_comb begin
    case (op)
      csrPkg::csrRw: writeValM = src;
      csrPkg::csrRs: writeValM = readValM | src;
      csrPkg::csrRc: writeValM = readValM & ~src;
      default:       writeValM = readValM;
    endcase
  end

  ////////////////////////////////////////
  // Legality check
  ////////////////////////////////////////

  // Address bits 9:8 give the lowest level allowed to touch the CSR
  assign privTooLow    = adr[9:8] > privMode;
  // Bits 11:10 both set mark a read-only CSR
  assign readOnlyWrite = writesReg && (adr[11:10] == 2'b11);

  assign illegal = csrValid && (!anyHit || privTooLow || readOnlyWrite);

  // Write strobe only for an accepted legal writing access
  assign doWrite = csrValid && !stall && !illegal && writesReg;

  // Both banks see the same request and decode their own addresses
  assign machineBus.adr      = adr;
  assign machineBus.write    = doWrite;
  assign machineBus.writeVal = writeValM;
  assign counterBus.adr      = adr;
  assign counterBus.write    = doWrite;
  assign counterBus.writeVal = writeValM;

  ////////////////////////////////////////
  // Writeback register
  ////////////////////////////////////////

  // Flush wins over stall
  // Illegal or idle cycles leave zero so no machine state leaks to user code
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      readValW <= '0;
    end else if (!stall) begin
      readValW <= (csrValid && !illegal) ? readValM : '0;
    end
  end

endmodule

`default_nettype wire

/* logic/csrMachine.sv */
`include "csr_macros.svh"
`default_nettype none

module csrMachine (
  input  logic                 clk,
  input  logic                 reset,
  csrAccessIf.bank             bus,
  input  logic                 trap,
  input  logic                 mret,
  input  logic                 timerInt,
  input  logic                 extInt,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic [`CSR_XLEN-1:0] cause,
  input  logic [`CSR_XLEN-1:0] faultValue,
  output logic [`CSR_XLEN-1:0] trapVector,
  output logic [`CSR_XLEN-1:0] epc,
  output csrPkg::privLevel     privMode,
  output logic                 interruptPending
);

  // Machine timer and external interrupt bits in mip and mie
  localparam int mtiBit = 7;
  localparam int meiBit = 11;
  localparam logic [`CSR_XLEN-1:0] intMask = (`CSR_XLEN'(1) << mtiBit) |
                                             (`CSR_XLEN'(1) << meiBit);

  // mstatus fields kept apart, the rest reads as zero
  logic                 statusMie;
  logic                 statusMpie;
  csrPkg::privLevel     statusMpp;
  logic [`CSR_XLEN-1:0] mieReg;
  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] mcause;
  logic [`CSR_XLEN-1:0] mtval;
  logic [`CSR_XLEN-1:0] mstatusVal;
  logic [`CSR_XLEN-1:0] mipVal;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  always_comb begin
    mstatusVal = '0;
    mstatusVal[`MSTATUS_MIE] = statusMie;
    mstatusVal[`MSTATUS_MPIE] = statusMpie;
    mstatusVal[`MSTATUS_MPP +: 2] = statusMpp;
  end

  // mip follows the interrupt lines, writes are dropped
  always_comb begin
    mipVal = '0;
    mipVal[mtiBit] = timerInt;
    mipVal[meiBit] = extInt;
  end

  always_comb begin
    bus.readVal = '0;
    bus.hit = 1'b1;
    case (bus.adr)
      `CSR_MSTATUS:  bus.readVal = mstatusVal;
      `CSR_MIE:      bus.readVal = mieReg;
      `CSR_MTVEC:    bus.readVal = mtvec;
      `CSR_MSCRATCH: bus.readVal = mscratch;
      `CSR_MEPC:     bus.readVal = mepc;
      `CSR_MCAUSE:   bus.readVal = mcause;
      `CSR_MTVAL:    bus.readVal = mtval;
      `CSR_MIP:      bus.readVal = mipVal;
      default:       bus.hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Update side
  ////////////////////////////////////////

  // Trap beats mret, both beat a CSR write in the same cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      statusMie  <= 1'b0;
      statusMpie <= 1'b0;
      statusMpp  <= csrPkg::privU;
      mieReg     <= '0;
      mtvec      <= '0;
      mscratch   <= '0;
      mepc       <= '0;
      mcause     <= '0;
      mtval      <= '0;
      privMode   <= csrPkg::privM;
    end else if (trap) begin
      mepc       <= {pc[`CSR_XLEN-1:1], 1'b0};
      mcause     <= cause;
      mtval      <= faultValue;
      statusMpie <= statusMie;
      statusMie  <= 1'b0;
      statusMpp  <= privMode;
      privMode   <= csrPkg::privM;
    end else if (mret) begin
      statusMie  <= statusMpie;
      statusMpie <= 1'b1;
      privMode   <= statusMpp;
      statusMpp  <= csrPkg::privU;
    end else if (bus.write) begin
      case (bus.adr)
        `CSR_MSTATUS: begin
          statusMie  <= bus.writeVal[`MSTATUS_MIE];
          statusMpie <= bus.writeVal[`MSTATUS_MPIE];
          // Only M is kept, anything else falls back to U
          statusMpp  <= (bus.writeVal[`MSTATUS_MPP +: 2] == 2'b11) ?
                        csrPkg::privM : csrPkg::privU;
        end
        `CSR_MIE:      mieReg   <= bus.writeVal & intMask;
        `CSR_MTVEC:    mtvec    <= {bus.writeVal[`CSR_XLEN-1:2], 2'b00};
        `CSR_MSCRATCH: mscratch <= bus.writeVal;
        `CSR_MEPC:     mepc     <= {bus.writeVal[`CSR_XLEN-1:1], 1'b0};
        `CSR_MCAUSE:   mcause   <= bus.writeVal;
        `CSR_MTVAL:    mtval    <= bus.writeVal;
        default: ;
      endcase
    end
  end

  assign trapVector = mtvec;
  assign epc        = mepc;

  // User mode always takes machine interrupts, machine mode needs MIE
  assign interruptPending = |(mipVal & mieReg) &&
                            (statusMie || (privMode == csrPkg::privU));

endmodule

`default_nettype wire

/* logic/csrCounters.sv */
`include "csr_macros.svh"
`default_nettype none

module csrCounters (
  input  logic     clk,
  input  logic     reset,
  input  logic     instrRetired,
  csrAccessIf.bank bus
);

  // CY at bit 0 and IR at bit 2, bit 1 is not built
  localparam logic [`CSR_XLEN-1:0] inhibitMask = `CSR_XLEN'h5;

  logic [`CSR_XLEN-1:0] mcycle;
  logic [`CSR_XLEN-1:0] minstret;
  logic [`CSR_XLEN-1:0] inhibit;
  logic                 writeCycle;
  logic                 writeInstret;

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // User copies alias the machine counters
  always_comb begin
    bus.readVal = '0;
    bus.hit = 1'b1;
    case (bus.adr)
      `CSR_MCOUNTINHIBIT: bus.readVal = inhibit;
      `CSR_MCYCLE:        bus.readVal = mcycle;
      `CSR_CYCLE:         bus.readVal = mcycle;
      `CSR_MINSTRET:      bus.readVal = minstret;
      `CSR_INSTRET:       bus.readVal = minstret;
      default:            bus.hit = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // Update side
  ////////////////////////////////////////

  // Only the machine addresses write, the user copies never do
  assign writeCycle   = bus.write && (bus.adr == `CSR_MCYCLE);
  assign writeInstret = bus.write && (bus.adr == `CSR_MINSTRET);

  always_ff @(posedge clk) begin
    if (reset) begin
      mcycle   <= '0;
      minstret <= '0;
      inhibit  <= '0;
    end else begin
      // A write replaces the increment of that cycle
      if (writeCycle) begin
        mcycle <= bus.writeVal;
      end else if (!inhibit[0]) begin
        mcycle <= mcycle + 1'b1;
      end
      if (writeInstret) begin
        minstret <= bus.writeVal;
      end else if (instrRetired && !inhibit[2]) begin
        minstret <= minstret + 1'b1;
      end
      if (bus.write && (bus.adr == `CSR_MCOUNTINHIBIT)) begin
        inhibit <= bus.writeVal & inhibitMask;
      end
    end
  end

endmodule

`default_nettype wire

/* logic/csrFile.sv */
`include "csr_macros.svh"
`default_nettype none

module csrFile (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 stall,
  input  logic                 flush,
  input  logic                 csrValid,
  input  logic                 trap,
  input  logic                 mret,
  input  logic                 instrRetired,
  input  logic                 timerInt,
  input  logic                 extInt,
  input  logic [31:0]          instr,
  input  logic [`CSR_XLEN-1:0] srcA,
  input  logic [`CSR_XLEN-1:0] pc,
  input  logic [`CSR_XLEN-1:0] cause,
  input  logic [`CSR_XLEN-1:0] faultValue,
  output logic [`CSR_XLEN-1:0] readValW,
  output logic [`CSR_XLEN-1:0] trapVector,
  output logic [`CSR_XLEN-1:0] epc,
  output logic                 illegal,
  output logic                 interruptPending,
  output logic [1:0]           privMode
);

  // Current level, owned by the machine bank
  csrPkg::privLevel curPriv;

  // One access port per bank
  csrAccessIf machineBus ();
  csrAccessIf counterBus ();

  csrAccessStage stage (
    .clk        (clk),
    .reset      (reset),
    .stall      (stall),
    .flush      (flush),
    .csrValid   (csrValid),
    .instr      (instr),
    .srcA       (srcA),
    .privMode   (curPriv),
    .machineBus (machineBus.stage),
    .counterBus (counterBus.stage),
    .readValW   (readValW),
    .illegal    (illegal)
  );

  csrMachine machine (
    .clk              (clk),
    .reset            (reset),
    .bus              (machineBus.bank),
    .trap             (trap),
    .mret             (mret),
    .timerInt         (timerInt),
    .extInt           (extInt),
    .pc               (pc),
    .cause            (cause),
    .faultValue       (faultValue),
    .trapVector       (trapVector),
    .epc              (epc),
    .privMode         (curPriv),
    .interruptPending (interruptPending)
  );

  csrCounters counters (
    .clk          (clk),
    .reset        (reset),
    .instrRetired (instrRetired),
    .bus          (counterBus.bank)
  );

  // Enum leaves the unit as a plain 2-bit code
  assign privMode = curPriv;

endmodule

`default_nettype wire

/* tests/csrFile_sva.sv */
`include "csr_macros.svh"
`default_nettype none

module csrFile_sva (
  input logic                 clk,
  input logic                 reset,
  input logic                 stall,
  input logic                 flush,
  input logic [`CSR_XLEN-1:0] readValW,
  input logic [1:0]           privMode
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failed assertions, read by the testbench top
  int failCount = 0;

  // Only U and M are built
  privLegal: assert property (@(posedge clk) disable iff (reset)
    (privMode == 2'b00) || (privMode == 2'b11))
  else begin
    failCount++;
    $error("privMode holds a level that is not built");
  end

  // Writeback register frozen while stalled
  stallHolds: assert property (@(posedge clk) disable iff (reset)
    (stall && !flush) |=> $stable(readValW))
  else begin
    failCount++;
    $error("readValW changed during a stall");
  end

  // Flush clears the writeback value
  flushZeroes: assert property (@(posedge clk) disable iff (reset)
    flush |=> (readValW == '0))
  else begin
    failCount++;
    $error("readValW is not zero after a flush");
  end

endmodule

`default_nettype wire

/* tests/csrFile_checker.sv */
`include "csr_macros.svh"
`default_nettype none

module csrFile_checker (
  input  logic        clk,
  input  logic        reset,
  input  logic        stall,
  input  logic        flush,
  input  logic        csrValid,
  input  logic        trap,
  input  logic        mret,
  input  logic        instrRetired,
  input  logic        timerInt,
  input  logic        extInt,
  input  logic [31:0] instr,
  input  logic [31:0] srcA,
  input  logic [31:0] pc,
  input  logic [31:0] cause,
  input  logic [31:0] faultValue,
  input  logic [31:0] readValW,
  input  logic [31:0] trapVector,
  input  logic [31:0] epc,
  input  logic        illegal,
  input  logic        interruptPending,
  input  logic [1:0]  privMode,
  input  logic        done,
  input  logic [31:0] assertFails,
  output int          errCount
);
  timeunit 1ns;
  timeprecision 1ps;

  // Every register the unit keeps, as the model sees it
  typedef struct packed {
    logic        mie;
    logic        mpie;
    logic [1:0]  mpp;
    logic [1:0]  priv;
    logic [31:0] mieReg;
    logic [31:0] mtvec;
    logic [31:0] mscratch;
    logic [31:0] mepc;
    logic [31:0] mcause;
    logic [31:0] mtval;
    logic [31:0] inhibit;
    logic [31:0] mcycle;
    logic [31:0] minstret;
    logic [31:0] readValW;
  } csrModel;

  csrModel model;
  int      checkCount;

  initial begin
    errCount = 0;
    checkCount = 0;
  end

  ////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////

  // Bit 32 is set when some bank owns the address
  function automatic logic [32:0] csrRead(input csrModel m, input logic [11:0] adr,
                                          input logic ti, input logic ei);
    logic [31:0] status;
    status = 32'h0;
    status[`MSTATUS_MIE] = m.mie;
    status[`MSTATUS_MPIE] = m.mpie;
    status[`MSTATUS_MPP +: 2] = m.mpp;
    case (adr)
      `CSR_MSTATUS:       return {1'b1, status};
      `CSR_MIE:           return {1'b1, m.mieReg};
      `CSR_MTVEC:         return {1'b1, m.mtvec};
      `CSR_MSCRATCH:      return {1'b1, m.mscratch};
      `CSR_MEPC:          return {1'b1, m.mepc};
      `CSR_MCAUSE:        return {1'b1, m.mcause};
      `CSR_MTVAL:         return {1'b1, m.mtval};
      // Timer at bit 7, external at bit 11
      `CSR_MIP:           return {1'b1, 20'h0, ei, 3'b000, ti, 7'h00};
      `CSR_MCOUNTINHIBIT: return {1'b1, m.inhibit};
      `CSR_MCYCLE,
      `CSR_CYCLE:         return {1'b1, m.mcycle};
      `CSR_MINSTRET,
      `CSR_INSTRET:       return {1'b1, m.minstret};
      default:            return 33'h0;
    endcase
  endfunction

  // Write always, set and clear only with a nonzero rs1 field
  function automatic logic writesCsr(input logic [31:0] ins);
    return (ins[13:12] == 2'b01) || (ins[13] && (ins[19:15] != 5'd0));
  endfunction

  function automatic logic illegalAccess(input csrModel m, input logic valid,
                                         input logic [31:0] ins, input logic ti,
                                         input logic ei);
    logic [32:0] rd;
    rd = csrRead(m, ins[31:20], ti, ei);
    return valid && (!rd[32] || (ins[29:28] > m.priv) ||
                     (writesCsr(ins) && (ins[31:30] == 2'b11)));
  endfunction

  function automatic logic pendingIrq(input csrModel m, input logic ti, input logic ei);
    logic [31:0] mip;
    mip = {20'h0, ei, 3'b000, ti, 7'h00};
    return (|(mip & m.mieReg)) && (m.mie || (m.priv == 2'b00));
  endfunction

  // State after one rising edge
  function automatic csrModel nextState(input csrModel m, input logic valid,
                                        input logic stl, input logic fls,
                                        input logic trp, input logic ret,
                                        input logic retired, input logic ti,
                                        input logic ei, input logic [31:0] ins,
                                        input logic [31:0] rs, input logic [31:0] tpc,
                                        input logic [31:0] tcause,
                                        input logic [31:0] tval);
    csrModel     n;
    logic [32:0] rd;
    logic [31:0] src;
    logic [31:0] wv;
    logic [11:0] adr;
    logic        bad;
    logic        wr;
    n = m;
    adr = ins[31:20];
    rd = csrRead(m, adr, ti, ei);
    src = ins[14] ? {27'h0, ins[19:15]} : rs;
    case (ins[13:12])
      2'b01:   wv = src;
      2'b10:   wv = rd[31:0] | src;
      2'b11:   wv = rd[31:0] & ~src;
      default: wv = rd[31:0];
    endcase
    bad = illegalAccess(m, valid, ins, ti, ei);
    wr = valid && !stl && !bad && writesCsr(ins);
    // Counters, a write replaces the increment
    if (wr && (adr == `CSR_MCYCLE)) n.mcycle = wv;
    else if (!m.inhibit[0]) n.mcycle = m.mcycle + 32'd1;
    if (wr && (adr == `CSR_MINSTRET)) n.minstret = wv;
    else if (retired && !m.inhibit[2]) n.minstret = m.minstret + 32'd1;
    if (wr && (adr == `CSR_MCOUNTINHIBIT)) n.inhibit = wv & 32'h5;
    // Trap first, then mret, then the CSR write
    if (trp) begin
      n.mepc = {tpc[31:1], 1'b0};
      n.mcause = tcause;
      n.mtval = tval;
      n.mpie = m.mie;
      n.mie = 1'b0;
      n.mpp = m.priv;
      n.priv = 2'b11;
    end else if (ret) begin
      n.mie = m.mpie;
      n.mpie = 1'b1;
      n.priv = m.mpp;
      n.mpp = 2'b00;
    end else if (wr) begin
      case (adr)
        `CSR_MSTATUS: begin
          n.mie = wv[`MSTATUS_MIE];
          n.mpie = wv[`MSTATUS_MPIE];
          n.mpp = (wv[`MSTATUS_MPP +: 2] == 2'b11) ? 2'b11 : 2'b00;
        end
        `CSR_MIE:      n.mieReg = wv & 32'h0000_0880;
        `CSR_MTVEC:    n.mtvec = {wv[31:2], 2'b00};
        `CSR_MSCRATCH: n.mscratch = wv;
        `CSR_MEPC:     n.mepc = {wv[31:1], 1'b0};
        `CSR_MCAUSE:   n.mcause = wv;
        `CSR_MTVAL:    n.mtval = wv;
        default: ;
      endcase
    end
    // Writeback register, flush over stall
    if (fls) n.readValW = 32'h0;
    else if (!stl) n.readValW = (valid && !bad) ? rd[31:0] : 32'h0;
    return n;
  endfunction

  ////////////////////////////////////////
  // Comparison
  ////////////////////////////////////////

  task automatic compareValue(input string what, input logic [31:0] got,
                              input logic [31:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // Outputs are stable here, inputs changed on the falling edge
  always @(posedge clk) begin
    if (reset) begin
      model = '0;
      model.priv = 2'b11;
    end else begin
      compareValue("readValW", readValW, model.readValW);
      compareValue("trapVector", trapVector, model.mtvec);
      compareValue("epc", epc, model.mepc);
      compareValue("privMode", {30'h0, privMode}, {30'h0, model.priv});
      compareValue("illegal", {31'h0, illegal},
                   {31'h0, illegalAccess(model, csrValid, instr, timerInt, extInt)});
      compareValue("interruptPending", {31'h0, interruptPending},
                   {31'h0, pendingIrq(model, timerInt, extInt)});
      model = nextState(model, csrValid, stall, flush, trap, mret, instrRetired,
                        timerInt, extInt, instr, srcA, pc, cause, faultValue);
    end
  end

  always @(posedge done) begin
    $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
             checkCount, errCount, assertFails);
  end

endmodule

`default_nettype wire

/* tests/csrFile_tb.sv */
`include "csr_macros.svh"
`default_nettype none

module csrFile_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numTests    = 4000;
  localparam int resetCycles = 10;
  // Reset, every test cycle and a margin
  localparam int cycleLimit  = resetCycles + numTests + 200;

  logic        clk;
  logic        reset;
  logic        stall;
  logic        flush;
  logic        csrValid;
  logic        trap;
  logic        mret;
  logic        instrRetired;
  logic        timerInt;
  logic        extInt;
  logic [31:0] instr;
  logic [31:0] srcA;
  logic [31:0] pc;
  logic [31:0] cause;
  logic [31:0] faultValue;
  logic [31:0] readValW;
  logic [31:0] trapVector;
  logic [31:0] epc;
  logic        illegal;
  logic        interruptPending;
  logic [1:0]  privMode;
  logic        done;
  logic [31:0] assertFails;
  logic [31:0] lfsr;
  int          errCount;
  int          cycleCount;

  csrFile csrFile_i (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .csrValid(csrValid),
    .trap(trap), .mret(mret), .instrRetired(instrRetired), .timerInt(timerInt),
    .extInt(extInt), .instr(instr), .srcA(srcA), .pc(pc), .cause(cause),
    .faultValue(faultValue), .readValW(readValW), .trapVector(trapVector),
    .epc(epc), .illegal(illegal), .interruptPending(interruptPending),
    .privMode(privMode)
  );

  bind csrFile csrFile_sva propChecks (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush),
    .readValW(readValW), .privMode(privMode)
  );

  assign assertFails = csrFile_i.propChecks.failCount;

  csrFile_checker portChecker (
    .clk(clk), .reset(reset), .stall(stall), .flush(flush), .csrValid(csrValid),
    .trap(trap), .mret(mret), .instrRetired(instrRetired), .timerInt(timerInt),
    .extInt(extInt), .instr(instr), .srcA(srcA), .pc(pc), .cause(cause),
    .faultValue(faultValue), .readValW(readValW), .trapVector(trapVector),
    .epc(epc), .illegal(illegal), .interruptPending(interruptPending),
    .privMode(privMode), .done(done), .assertFails(assertFails), .errCount(errCount)
  );

  ////////////////////////////////////////
  // Clock and run limit
  ////////////////////////////////////////

  initial clk = 1'b0;
  always #10 clk = ~clk;

  initial cycleCount = 0;
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: the run went past %0d clock cycles", cycleLimit);
      $display("Testbench failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Random stimulus
  ////////////////////////////////////////

  // Galois LFSR, taps 32, 22, 2, 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrStep(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  // True once in 2**n draws
  task automatic drawChance(input int n, output logic hit);
    logic [31:0] r;
    drawBits(n, r);
    hit = (r == 32'h0);
  endtask

  // Legal CSRs plus three no bank owns
  function automatic logic [11:0] pickAdr(input logic [3:0] idx);
    case (idx)
      4'd0:    return `CSR_MSTATUS;
      4'd1:    return `CSR_MIE;
      4'd2:    return `CSR_MTVEC;
      4'd3:    return `CSR_MSCRATCH;
      4'd4:    return `CSR_MEPC;
      4'd5:    return `CSR_MCAUSE;
      4'd6:    return `CSR_MTVAL;
      4'd7:    return `CSR_MIP;
      4'd8:    return `CSR_MCOUNTINHIBIT;
      4'd9:    return `CSR_MCYCLE;
      4'd10:   return `CSR_MINSTRET;
      4'd11:   return `CSR_CYCLE;
      4'd12:   return `CSR_INSTRET;
      4'd13:   return 12'h301;
      4'd14:   return 12'h7C0;
      default: return 12'h001;
    endcase
  endfunction

  task automatic driveCycle();
    logic [31:0] r;
    logic [11:0] adr;
    logic [2:0]  funct3;
    logic [4:0]  rs1;
    logic        flip;
    drawBits(4, r);
    adr = pickAdr(r[3:0]);
    drawBits(3, r);
    funct3 = r[2:0];
    // Zero rs1 often, so set and clear sometimes only read
    drawBits(5, r);
    rs1 = r[4:0];
    drawChance(2, flip);
    if (flip) rs1 = 5'd0;
    instr = {adr, rs1, funct3, 5'd1, 7'b1110011};
    drawBits(32, r);
    srcA = r;
    drawBits(2, r);
    csrValid = (r[1:0] != 2'b00);
    drawChance(3, stall);
    drawChance(4, flush);
    drawChance(4, trap);
    drawChance(4, mret);
    drawBits(1, r);
    instrRetired = r[0];
    drawChance(3, flip);
    if (flip) timerInt = ~timerInt;
    drawChance(3, flip);
    if (flip) extInt = ~extInt;
    drawBits(32, r);
    pc = r;
    drawBits(32, r);
    cause = r;
    drawBits(32, r);
    faultValue = r;
  endtask

  initial begin
    lfsr = 32'h9c7a_2a14;
    done = 1'b0;
    reset = 1'b1;
    {stall, flush, csrValid, trap, mret, instrRetired, timerInt, extInt} = '0;
    instr = '0;
    srcA = '0;
    pc = '0;
    cause = '0;
    faultValue = '0;
    repeat (resetCycles) @(negedge clk);
    reset = 1'b0;
    repeat (numTests) begin
      driveCycle();
      @(negedge clk);
    end
    // Idle one cycle so the last access gets compared
    {stall, flush, csrValid, trap, mret} = '0;
    @(negedge clk);
    done = 1'b1;
    #1;
    if ((errCount == 0) && (assertFails == 0)) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+include
logic/csrPkg.sv
logic/csrAccessIf.sv
logic/csrAccessStage.sv
logic/csrMachine.sv
logic/csrCounters.sv
logic/csrFile.sv
tests/csrFile_sva.sv
tests/csrFile_checker.sv
tests/csrFile_tb.sv
